// ==== source/rx_ppe_pkg.sv ====
/*
 * Receive pre-processing stage shared definitions
 * Word, port, class and length types, header field positions
 * and the parser state encoding
 */

`default_nettype none

package rx_ppe_pkg;

   // ==============================
   // Widths
   // ==============================

   // Packet word
   localparam int DATA_W = 64;
   // Ingress port number
   localparam int PORT_W = 4;
   // Traffic classes, one pause bit each
   localparam int NUM_TC = 8;
   localparam int TC_W   = $clog2(NUM_TC);
   // Header length field
   localparam int LEN_W  = 16;

   // ==============================
   // Header word layout
   // ==============================

   // Packet length in words, header included
   localparam int HDR_LEN_LSB = 0;
   // Priority code point, maps straight to traffic class
   localparam int HDR_PCP_LSB = 16;

   // ==============================
   // Types
   // ==============================

   typedef logic [DATA_W-1:0] data_t;
   typedef logic [PORT_W-1:0] port_t;
   typedef logic [TC_W-1:0]   tc_t;
   typedef logic [LEN_W-1:0]  pkt_len_t;
   typedef logic [NUM_TC-1:0] xoff_t;

   // Parser FSM
   typedef enum logic {
      IDLE,   // Waiting for a header word
      BODY    // Inside a packet, counting words
   } parse_state_t;

endpackage

`default_nettype wire

// ==== source/rx_ppe_in_buf.sv ====
/*
 * Input buffer of the receive pre-processing stage
 * Circular word FIFO filled by the link; each released entry
 * returns one credit to the sender
 */

`default_nettype none

module rx_ppe_in_buf
   import rx_ppe_pkg::*;
#(
   parameter int IN_DEPTH = 8
) (
   input  wire   fab_clk,
   input  wire   arst_n,
   // Link side
   input  wire   in_valid,
   input  data_t in_data,
   input  wire   in_sop,
   input  wire   in_eop,
   input  port_t in_port,
   output logic  in_credit,
   // Head of buffer towards the parser
   input  wire   buf_pop,
   output logic  buf_valid,
   output data_t buf_data,
   output logic  buf_sop,
   output logic  buf_eop,
   output port_t buf_port
);

   // ==============================
   // Storage and pointers
   // ==============================

   localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
   localparam int CNT_W = $clog2(IN_DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(IN_DEPTH - 1);

   data_t            mem_data [IN_DEPTH];
   logic             mem_sop  [IN_DEPTH];
   logic             mem_eop  [IN_DEPTH];
   port_t            mem_port [IN_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   // Occupancy, bounded by the sender's credits
   logic [CNT_W-1:0] count;
   logic             pop;

   // Only pop a real entry
   assign pop = buf_pop && buf_valid;

   // Entry array, written whenever the link presents a word
   always_ff @(posedge fab_clk) begin
      if (in_valid) begin
         mem_data[wr_ptr] <= in_data;
         mem_sop[wr_ptr]  <= in_sop;
         mem_eop[wr_ptr]  <= in_eop;
         mem_port[wr_ptr] <= in_port;
      end
   end

   // Pointers wrap at the last entry
   // Count moves only when one side is active alone
   always_ff @(posedge fab_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (in_valid) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         case ({in_valid, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // ==============================
   // Credit return
   // ==============================

   // One pulse in the cycle after each pop
   always_ff @(posedge fab_clk or negedge arst_n) begin
      if (!arst_n) begin
         in_credit <= 1'b0;
      end else begin
         in_credit <= pop;
      end
   end

   // Head entry, visible right after the write edge
   assign buf_valid = (count != '0);
   assign buf_data  = mem_data[rd_ptr];
   assign buf_sop   = mem_sop[rd_ptr];
   assign buf_eop   = mem_eop[rd_ptr];
   assign buf_port  = mem_port[rd_ptr];

endmodule

`default_nettype wire

// ==== source/rx_ppe_parser.sv ====
/*
 * Header parser of the receive pre-processing stage
 * Decodes class and length from each header word, counts the
 * packet's words and tags every word with port, class and error
 */

`default_nettype none

module rx_ppe_parser
   import rx_ppe_pkg::*;
(
   input  wire   fab_clk,
   input  wire   arst_n,
   // Head of input buffer
   input  wire   buf_valid,
   input  data_t buf_data,
   input  wire   buf_sop,
   input  wire   buf_eop,
   input  port_t buf_port,
   output logic  buf_pop,
   // Tagged word towards the output stage
   input  wire   par_ready,
   output logic  par_valid,
   output data_t par_data,
   output logic  par_sop,
   output logic  par_eop,
   output port_t par_port,
   output tc_t   par_tc,
   output logic  par_err
);

   parse_state_t state;
   // Words seen so far in the current packet, header included
   pkt_len_t     word_cnt;
   // Fields latched from the header word
   tc_t          tc_q;
   port_t        port_q;
   pkt_len_t     len_q;

   tc_t          hdr_tc;
   pkt_len_t     hdr_len;
   tc_t          cur_tc;
   port_t        cur_port;
   pkt_len_t     cur_len;
   pkt_len_t     cnt_next;
   logic         len_err;

   // ==============================
   // Header decode
   // ==============================

   assign hdr_tc  = buf_data[HDR_PCP_LSB +: TC_W];
   assign hdr_len = buf_data[HDR_LEN_LSB +: LEN_W];

   // In IDLE the head word is the header itself
   // Words after it reuse the latched fields
   always_comb begin
      if (state == IDLE) begin
         cur_tc   = hdr_tc;
         cur_port = buf_port;
         cur_len  = hdr_len;
         cnt_next = pkt_len_t'(1);
      end else begin
         cur_tc   = tc_q;
         cur_port = port_q;
         cur_len  = len_q;
         cnt_next = word_cnt + 1'b1;
      end
   end

   // Checked on the end word only, a one-word packet included
   assign len_err = buf_eop && (cnt_next != cur_len);

   // Pop when the output register is empty or being taken
   assign buf_pop = buf_valid && (!par_valid || par_ready);

   // ==============================
   // FSM and word counter
   // ==============================

   always_ff @(posedge fab_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= IDLE;
         word_cnt <= '0;
      end else if (buf_pop) begin
         word_cnt <= cnt_next;
         // An end word closes the packet, else keep counting
         state    <= buf_eop ? IDLE : BODY;
      end
   end

   always_ff @(posedge fab_clk) begin
      if (buf_pop && state == IDLE) begin
         tc_q   <= hdr_tc;
         port_q <= buf_port;
         len_q  <= hdr_len;
      end
   end

   // ==============================
   // Output register
   // ==============================

   always_ff @(posedge fab_clk or negedge arst_n) begin
      if (!arst_n) begin
         par_valid <= 1'b0;
      end else if (buf_pop) begin
         par_valid <= 1'b1;
      end else if (par_ready) begin
         par_valid <= 1'b0;
      end
   end

   // Holds while stalled
   always_ff @(posedge fab_clk) begin
      if (buf_pop) begin
         par_data <= buf_data;
         par_sop  <= buf_sop;
         par_eop  <= buf_eop;
         par_port <= cur_port;
         par_tc   <= cur_tc;
         par_err  <= len_err;
      end
   end

endmodule

`default_nettype wire

// ==== source/rx_ppe_out_ctrl.sv ====
/*
 * Output stage of the receive pre-processing stage
 * Sends tagged words downstream against consumer credits and
 * holds back packet starts whose class is paused
 */

`default_nettype none

module rx_ppe_out_ctrl
   import rx_ppe_pkg::*;
#(
   parameter int OUT_CREDITS = 4
) (
   input  wire   fab_clk,
   input  wire   arst_n,
   // Tagged word from the parser
   input  wire   par_valid,
   input  data_t par_data,
   input  wire   par_sop,
   input  wire   par_eop,
   input  port_t par_port,
   input  tc_t   par_tc,
   input  wire   par_err,
   output logic  par_ready,
   // Pause and credit return
   input  xoff_t pfc_xoff,
   input  wire   out_credit,
   // Downstream consumer
   output logic  out_valid,
   output data_t out_data,
   output logic  out_sop,
   output logic  out_eop,
   output port_t out_port,
   output tc_t   out_tc,
   output logic  out_err
);

   localparam int CRD_W = $clog2(OUT_CREDITS + 1);

   logic [CRD_W-1:0] credit_cnt;
   logic             paused;
   logic             send;

   // ==============================
   // Flow control
   // ==============================

   // Only a packet start looks at pause
   // Body words follow their start regardless
   assign paused    = par_valid && par_sop && pfc_xoff[par_tc];
   // Count held in the register, a credit arriving now is not usable yet
   assign par_ready = (credit_cnt != '0) && !paused;
   assign send      = par_valid && par_ready;

   // Spend on send, refill on out_credit, both may hit together
   always_ff @(posedge fab_clk or negedge arst_n) begin
      if (!arst_n) begin
         credit_cnt <= CRD_W'(OUT_CREDITS);
      end else begin
         case ({send, out_credit})
            2'b10:   credit_cnt <= credit_cnt - 1'b1;
            2'b01:   credit_cnt <= credit_cnt + 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   // ==============================
   // Output register
   // ==============================

   // One cycle after acceptance
   always_ff @(posedge fab_clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= send;
      end
   end

   always_ff @(posedge fab_clk) begin
      if (send) begin
         out_data <= par_data;
         out_sop  <= par_sop;
         out_eop  <= par_eop;
         out_port <= par_port;
         out_tc   <= par_tc;
         out_err  <= par_err;
      end
   end

endmodule

`default_nettype wire

// ==== source/rx_ppe_top.sv ====
/*
 * Receive pre-processing stage top level
 * Input buffer, header parser and credit-gated output stage
 */

`default_nettype none

module rx_ppe_top
   import rx_ppe_pkg::*;
#(
   parameter int IN_DEPTH    = 8,
   parameter int OUT_CREDITS = 4
) (
   input  wire   fab_clk,
   input  wire   arst_n,
   // Link
   input  wire   in_valid,
   input  data_t in_data,
   input  wire   in_sop,
   input  wire   in_eop,
   input  port_t in_port,
   output logic  in_credit,
   // Per-class pause
   input  xoff_t pfc_xoff,
   // Downstream
   output logic  out_valid,
   output data_t out_data,
   output logic  out_sop,
   output logic  out_eop,
   output port_t out_port,
   output tc_t   out_tc,
   output logic  out_err,
   input  wire   out_credit
);

   // ==============================
   // Buffer to parser
   // ==============================

   logic  buf_valid;
   data_t buf_data;
   logic  buf_sop;
   logic  buf_eop;
   port_t buf_port;
   logic  buf_pop;

   // ==============================
   // Parser to output stage
   // ==============================

   logic  par_valid;
   data_t par_data;
   logic  par_sop;
   logic  par_eop;
   port_t par_port;
   tc_t   par_tc;
   logic  par_err;
   logic  par_ready;

   rx_ppe_in_buf #(
      .IN_DEPTH (IN_DEPTH)
   ) in_buf_inst (
      .fab_clk   (fab_clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .in_sop    (in_sop),
      .in_eop    (in_eop),
      .in_port   (in_port),
      .in_credit (in_credit),
      .buf_pop   (buf_pop),
      .buf_valid (buf_valid),
      .buf_data  (buf_data),
      .buf_sop   (buf_sop),
      .buf_eop   (buf_eop),
      .buf_port  (buf_port)
   );

   rx_ppe_parser parser_inst (
      .fab_clk   (fab_clk),
      .arst_n    (arst_n),
      .buf_valid (buf_valid),
      .buf_data  (buf_data),
      .buf_sop   (buf_sop),
      .buf_eop   (buf_eop),
      .buf_port  (buf_port),
      .buf_pop   (buf_pop),
      .par_ready (par_ready),
      .par_valid (par_valid),
      .par_data  (par_data),
      .par_sop   (par_sop),
      .par_eop   (par_eop),
      .par_port  (par_port),
      .par_tc    (par_tc),
      .par_err   (par_err)
   );

   rx_ppe_out_ctrl #(
      .OUT_CREDITS (OUT_CREDITS)
   ) out_ctrl_inst (
      .fab_clk    (fab_clk),
      .arst_n     (arst_n),
      .par_valid  (par_valid),
      .par_data   (par_data),
      .par_sop    (par_sop),
      .par_eop    (par_eop),
      .par_port   (par_port),
      .par_tc     (par_tc),
      .par_err    (par_err),
      .par_ready  (par_ready),
      .pfc_xoff   (pfc_xoff),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_sop    (out_sop),
      .out_eop    (out_eop),
      .out_port   (out_port),
      .out_tc     (out_tc),
      .out_err    (out_err)
   );

endmodule

`default_nettype wire

// ==== verif/rx_ppe_props.sv ====
/*
 * Bound checks of the receive pre-processing stage
 * Credit bounds on both sides and the pause rule on packet starts
 */

`default_nettype none

module rx_ppe_props
   import rx_ppe_pkg::*;
#(
   parameter int IN_DEPTH    = 8,
   parameter int OUT_CREDITS = 4
) (
   input wire   fab_clk,
   input wire   arst_n,
   input wire   in_valid,
   input wire   in_credit,
   input wire   out_credit,
   input wire   out_valid,
   input wire   out_sop,
   input tc_t   out_tc,
   input xoff_t pfc_xoff
);

   // Shadow credit counts of sender and consumer
   int    in_crd;
   // Consumer view where each out_valid spends one credit
   int    out_crd;
   // Pause vector as seen by the send decision
   xoff_t xoff_q;

   always_ff @(posedge fab_clk or negedge arst_n) begin
      if (!arst_n) begin
         in_crd  <= IN_DEPTH;
         out_crd <= OUT_CREDITS;
         xoff_q  <= '0;
      end else begin
         in_crd  <= in_crd - int'(in_valid) + int'(in_credit);
         out_crd <= out_crd - int'(out_valid) + int'(out_credit);
         xoff_q  <= pfc_xoff;
      end
   end

   // ==============================
   // Properties
   // ==============================

   // A word only leaves against a credit
   send_has_credit: assert property (@(posedge fab_clk) disable iff (!arst_n)
      out_valid |-> (out_crd > 0))
      else $error("Word sent with no downstream credit left");

   // Start of packet never leaves for a class paused in the cycle before
   sop_not_paused: assert property (@(posedge fab_clk) disable iff (!arst_n)
      (out_valid && out_sop) |-> !xoff_q[out_tc])
      else $error("Packet start sent while its class was paused");

   credits_bounded: assert property (@(posedge fab_clk) disable iff (!arst_n)
      (in_crd >= 0) && (in_crd <= IN_DEPTH) && (out_crd <= OUT_CREDITS))
      else $error("Credit count out of range");

endmodule

bind rx_ppe_top rx_ppe_props #(
   .IN_DEPTH    (IN_DEPTH),
   .OUT_CREDITS (OUT_CREDITS)
) props_inst (
   .fab_clk    (fab_clk),
   .arst_n     (arst_n),
   .in_valid   (in_valid),
   .in_credit  (in_credit),
   .out_credit (out_credit),
   .out_valid  (out_valid),
   .out_sop    (out_sop),
   .out_tc     (out_tc),
   .pfc_xoff   (pfc_xoff)
);

`default_nettype wire

// ==== verif/rx_ppe_tb_top.sv ====
/*
 * Testbench of the receive pre-processing stage
 * LFSR-driven packets, pause and consumer credits, checked
 * against a queue model of the expected tagged words
 */

`default_nettype none

module rx_ppe_tb_top
   import rx_ppe_pkg::*;
();

   localparam int IN_DEPTH    = 8;
   localparam int OUT_CREDITS = 4;
   localparam int NUM_PKTS    = 200;
   localparam int MAX_WORDS   = 8;
   localparam int MAX_CYCLES  = NUM_PKTS * MAX_WORDS * 20;

   logic  fab_clk;
   logic  arst_n;
   logic  in_valid;
   data_t in_data;
   logic  in_sop;
   logic  in_eop;
   port_t in_port;
   logic  in_credit;
   xoff_t pfc_xoff;
   logic  out_valid;
   data_t out_data;
   logic  out_sop;
   logic  out_eop;
   port_t out_port;
   tc_t   out_tc;
   logic  out_err;
   logic  out_credit;

   // Model of expected words, tag is {sop, eop, port, tc, err}
   data_t       exp_data [$];
   logic [9:0]  exp_tag [$];

   logic [31:0] lfsr;
   int          checks = 0;
   int          errors = 0;
   int          cycles = 0;
   // Credit bookkeeping on both sides
   int          words_sent = 0;
   int          in_ret = 0;
   int          recv = 0;
   int          out_ret = 0;
   // Packet being sent
   int          pkts_sent = 0;
   int          word_idx = 0;
   int          pkt_words = 0;
   port_t       pkt_port;
   tc_t         pkt_tc;
   pkt_len_t    pkt_len;

   rx_ppe_top #(
      .IN_DEPTH    (IN_DEPTH),
      .OUT_CREDITS (OUT_CREDITS)
   ) rx_ppe_top_inst (
      .fab_clk    (fab_clk),
      .arst_n     (arst_n),
      .in_valid   (in_valid),
      .in_data    (in_data),
      .in_sop     (in_sop),
      .in_eop     (in_eop),
      .in_port    (in_port),
      .in_credit  (in_credit),
      .pfc_xoff   (pfc_xoff),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_sop    (out_sop),
      .out_eop    (out_eop),
      .out_port   (out_port),
      .out_tc     (out_tc),
      .out_err    (out_err),
      .out_credit (out_credit)
   );

   initial begin
      fab_clk = 1'b0;
      forever #5 fab_clk = ~fab_clk;
   end

   // ==============================
   // Random source
   // ==============================

   // Galois form, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One step per bit taken
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                                input string what);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // ==============================
   // Output checks, sampled mid-cycle
   // ==============================

   task automatic check_output();
      data_t      exp_d;
      logic [9:0] exp_t;
      if (in_credit) begin
         in_ret++;
         checks++;
         assert (in_ret <= words_sent) else begin
            errors++;
            $display("[ERROR] %0t: %0d link credits back for %0d words", $time,
                     in_ret, words_sent);
         end
      end
      if (out_valid) begin
         recv++;
         checks++;
         // Words held by the consumer stay within its grant
         assert (recv - out_ret <= OUT_CREDITS) else begin
            errors++;
            $display("[ERROR] %0t: %0d words outstanding at consumer", $time,
                     recv - out_ret);
         end
         // Pause vector still holds the value the send decision saw
         if (out_sop) begin
            checks++;
            assert (!pfc_xoff[out_tc]) else begin
               errors++;
               $display("[ERROR] %0t: start sent on paused class %0d", $time, out_tc);
            end
         end
         checks++;
         assert (exp_data.size() != 0) else begin
            errors++;
            $display("[ERROR] %0t: output word %h with none expected", $time, out_data);
         end
         if (exp_data.size() != 0) begin
            exp_d = exp_data.pop_front();
            exp_t = exp_tag.pop_front();
            compare_value(out_data, exp_d, "out_data");
            compare_value(64'(out_sop), 64'(exp_t[9]), "out_sop");
            compare_value(64'(out_eop), 64'(exp_t[8]), "out_eop");
            compare_value(64'(out_port), 64'(exp_t[7:4]), "out_port");
            compare_value(64'(out_tc), 64'(exp_t[3:1]), "out_tc");
            compare_value(64'(out_err), 64'(exp_t[0]), "out_err");
         end
      end
   endtask

   // ==============================
   // Stimulus, driven on falling edge
   // ==============================

   task automatic toggle_pause();
      tc_t cls;
      if (take_bits(2) == 64'd0) begin
         cls           = tc_t'(take_bits(TC_W));
         pfc_xoff[cls] = ~pfc_xoff[cls];
      end
   endtask

   task automatic return_credit();
      out_credit = 1'b0;
      if (recv > out_ret && take_bits(1) != 64'd0) begin
         out_credit = 1'b1;
         out_ret++;
      end
   endtask

   // Some packets carry a header length that misses the real count
   task automatic start_packet();
      pkt_words = int'(take_bits(3)) + 1;
      pkt_port  = port_t'(take_bits(PORT_W));
      pkt_tc    = tc_t'(take_bits(TC_W));
      if (take_bits(4) == 64'd0) begin
         pkt_len = pkt_len_t'(pkt_words + 1 + int'(take_bits(2)));
      end else begin
         pkt_len = pkt_len_t'(pkt_words);
      end
      pkts_sent++;
   endtask

   task automatic drive_link();
      data_t word;
      logic  last;
      logic  len_bad;
      in_valid = 1'b0;
      if ((word_idx != 0 || pkts_sent < NUM_PKTS) &&
          (IN_DEPTH - (words_sent - in_ret) > 0) && take_bits(2) != 64'd0) begin
         if (word_idx == 0) begin
            start_packet();
         end
         word = take_bits(DATA_W);
         if (word_idx == 0) begin
            word[HDR_PCP_LSB +: TC_W]  = pkt_tc;
            word[HDR_LEN_LSB +: LEN_W] = pkt_len;
         end
         last    = (word_idx == pkt_words - 1);
         len_bad = (int'(pkt_len) != pkt_words);
         in_valid = 1'b1;
         in_data  = word;
         in_sop   = (word_idx == 0);
         in_eop   = last;
         // Body words carry a random port, the header port must win
         in_port  = (word_idx == 0) ? pkt_port : port_t'(take_bits(PORT_W));
         exp_data.push_back(word);
         exp_tag.push_back({in_sop, last, pkt_port, pkt_tc, last && len_bad});
         words_sent++;
         word_idx = last ? 0 : word_idx + 1;
      end
   endtask

   initial begin
      lfsr       = 32'h270a;
      arst_n     = 1'b0;
      in_valid   = 1'b0;
      in_data    = '0;
      in_sop     = 1'b0;
      in_eop     = 1'b0;
      in_port    = '0;
      pfc_xoff   = '0;
      out_credit = 1'b0;
      repeat (2) @(posedge fab_clk);
      @(negedge fab_clk);
      arst_n = 1'b1;

      // Run until every packet is out and every consumer credit is back
      while (!(pkts_sent == NUM_PKTS && word_idx == 0 && exp_data.size() == 0 &&
               recv == out_ret) && cycles < MAX_CYCLES) begin
         @(negedge fab_clk);
         cycles++;
         check_output();
         toggle_pause();
         return_credit();
         drive_link();
      end

      if (cycles >= MAX_CYCLES) begin
         errors++;
         $display("Timeout after %0d cycles with %0d words still expected", cycles,
                  exp_data.size());
      end else begin
         checks++;
         // Link credits all home again
         assert (words_sent == in_ret) else begin
            errors++;
            $display("[ERROR] %0t: %0d link credits missing after drain", $time,
                     words_sent - in_ret);
         end
      end

      $display("Checks: %0d, errors: %0d, packets: %0d, words: %0d", checks, errors,
               pkts_sent, words_sent);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
source/rx_ppe_pkg.sv
source/rx_ppe_in_buf.sv
source/rx_ppe_parser.sv
source/rx_ppe_out_ctrl.sv
source/rx_ppe_top.sv
verif/rx_ppe_props.sv
verif/rx_ppe_tb_top.sv

// ==== Makefile ====
# Verilator build and run of the receive pre-processing stage testbench

VERILATOR ?= verilator
TOP       ?= rx_ppe_tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(wildcard source/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Result comes from the log, not the exit status of the pipe
run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
